// File: include/cpu_defs.svh
/* fixed widths and register numbers of the five-stage pipeline
   included by every RTL file that sizes a port or field */
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

// data word and word address width
`define XLEN 32

// register index width, 32 registers
`define REG_ADDR_W 5

// i-type immediate, sign extended to XLEN
`define IMM_W 17

// j-type target, zero extended to XLEN
`define TARGET_W 27

// return address register written by jal
`define LINK_REG 31

`endif

// File: src/cpuPkg.sv
/* encodings shared by the pipeline stages
   imported by the decode, hazard, execute, ALU and writeback logic */
package cpuPkg;

    // instruction bits 31:27
    typedef enum logic [4:0] {
        opRType = 5'd0,
        opJ     = 5'd1,
        opBne   = 5'd2,
        opJal   = 5'd3,
        opJr    = 5'd4,
        opAddi  = 5'd5,
        opBlt   = 5'd6,
        opSw    = 5'd7,
        opLw    = 5'd8
    } opcodeT;

    // r-type aluop field, bits 6:2
    typedef enum logic [4:0] {
        aluAdd = 5'd0,
        aluSub = 5'd1,
        aluAnd = 5'd2,
        aluOr  = 5'd3,
        aluSll = 5'd4,
        aluSra = 5'd5
    } aluOpT;

    // next PC source chosen in execute
    typedef enum logic [1:0] {sequential, branchTarget, jumpTarget, registerTarget} pcSelT;

    // register file write value source
    typedef enum logic [1:0] {aluResult, memData, linkAddr} wbSelT;

    // execute operand source
    typedef enum logic [1:0] {fromDx, fromXm, fromMw} bypassSelT;

endpackage

// File: src/alu.sv
/* integer ALU for the execute stage
   the compare flags feed branch resolution */
`include "cpu_defs.svh"

module alu (
    input  logic [`XLEN-1:0]       a,
    input  logic [`XLEN-1:0]       b,
    input  logic [`REG_ADDR_W-1:0] shamt,
    input  cpuPkg::aluOpT          op,
    output logic [`XLEN-1:0]       result,
    output logic                   notEqual,
    output logic                   lessThan
);
    import cpuPkg::*;

    always_comb begin
        case (op)
            aluAdd:  result = a + b;
            aluSub:  result = a - b;
            aluAnd:  result = a & b;
            aluOr:   result = a | b;
            // shifts act on a only
            aluSll:  result = a << shamt;
            aluSra:  result = $signed(a) >>> shamt;
            default: result = '0;
        endcase
    end

    assign notEqual = a != b;
    // blt is a signed compare
    assign lessThan = $signed(a) < $signed(b);

endmodule

// File: src/regFile.sv
/* 32 x 32 register file, two read ports and one write port
   r0 reads zero, a same-cycle write passes through to the read ports */
`include "cpu_defs.svh"

module regFile (
    input  logic                   clock,
    input  logic                   arstN,
    input  logic [`REG_ADDR_W-1:0] readAddrA,
    input  logic [`REG_ADDR_W-1:0] readAddrB,
    output logic [`XLEN-1:0]       readDataA,
    output logic [`XLEN-1:0]       readDataB,
    input  logic                   writeEn,
    input  logic [`REG_ADDR_W-1:0] writeAddr,
    input  logic [`XLEN-1:0]       writeData
);

    logic [`XLEN-1:0] regs [2**`REG_ADDR_W];

    always_ff @(posedge clock or negedge arstN) begin
        if (!arstN) begin
            regs <= '{default: '0};
        end else if (writeEn && writeAddr != '0) begin
            regs[writeAddr] <= writeData;
        end
    end

    // bypass the writeback stage into decode
    assign readDataA = (readAddrA == '0) ? '0 :
                       (writeEn && writeAddr == readAddrA) ? writeData : regs[readAddrA];
    assign readDataB = (readAddrB == '0) ? '0 :
                       (writeEn && writeAddr == readAddrB) ? writeData : regs[readAddrB];

endmodule

// File: src/hazardUnit.sv
/* bypass selection for both execute operands and load-use stall detection
   purely combinational apart from its timing check */
`include "cpu_defs.svh"

module hazardUnit (
    input  logic                   clock,
    input  logic                   arstN,
    input  logic [`REG_ADDR_W-1:0] readAddrA,
    input  logic [`REG_ADDR_W-1:0] readAddrB,
    input  logic [`REG_ADDR_W-1:0] dxSrcA,
    input  logic [`REG_ADDR_W-1:0] dxSrcB,
    input  logic [`REG_ADDR_W-1:0] dxDest,
    input  logic                   dxMemRead,
    input  logic [`REG_ADDR_W-1:0] xmDest,
    input  logic                   xmRegWrite,
    input  logic [`REG_ADDR_W-1:0] mwDest,
    input  logic                   mwRegWrite,
    output cpuPkg::bypassSelT      bypassA,
    output cpuPkg::bypassSelT      bypassB,
    output logic                   stall
);
    import cpuPkg::*;

    // youngest live producer wins
    function automatic bypassSelT pickSource(input logic [`REG_ADDR_W-1:0] src);
        pickSource = fromDx;
        if (mwRegWrite && mwDest != '0 && mwDest == src) begin
            pickSource = fromMw;
        end
        if (xmRegWrite && xmDest != '0 && xmDest == src) begin
            pickSource = fromXm;
        end
    endfunction

    assign bypassA = pickSource(dxSrcA);
    assign bypassB = pickSource(dxSrcB);

    // load data is not ready until the lw reaches MW
    assign stall = dxMemRead && dxDest != '0 &&
                   (readAddrA == dxDest || readAddrB == dxDest);

    // the bubble placed in DX cannot itself be a load
    singleStall: assert property (@(posedge clock) disable iff (!arstN)
        stall |=> !stall);

endmodule

// File: src/fetchUnit.sv
/* program counter and FD pipeline register
   holds on a load-use stall, loads the NOP when execute redirects */
`include "cpu_defs.svh"

module fetchUnit (
    input  logic             clock,
    input  logic             arstN,
    input  logic             stall,
    input  logic             redirect,
    input  logic [`XLEN-1:0] redirectPc,
    output logic [`XLEN-1:0] imemAddr,
    input  logic [`XLEN-1:0] imemData,
    output logic [`XLEN-1:0] fdInstr,
    output logic [`XLEN-1:0] fdPc
);

    logic [`XLEN-1:0] pc;

    // instruction memory reads in the same cycle
    assign imemAddr = pc;

    always_ff @(posedge clock or negedge arstN) begin
        if (!arstN) begin
            pc      <= '0;
            fdInstr <= '0;
            fdPc    <= '0;
        end else if (redirect) begin
            // redirect wins over a stall, fetched word is wrong path
            pc      <= redirectPc;
            fdInstr <= '0;
            fdPc    <= pc;
        end else if (!stall) begin
            pc      <= pc + 1'b1;
            fdInstr <= imemData;
            fdPc    <= pc;
        end
    end

    // decode keeps the same instruction across a stall
    holdOnStall: assert property (@(posedge clock) disable iff (!arstN)
        stall && !redirect |=> $stable(fdPc));

endmodule

// File: src/decodeControl.sv
/* decode stage: field split, control decode, register read addressing
   and the DX pipeline register, which takes the NOP on stall or flush */
`include "cpu_defs.svh"

module decodeControl (
    input  logic                   clock,
    input  logic                   arstN,
    input  logic [`XLEN-1:0]       fdInstr,
    input  logic [`XLEN-1:0]       fdPc,
    input  logic                   stall,
    input  logic                   flush,
    input  logic [`XLEN-1:0]       readDataA,
    input  logic [`XLEN-1:0]       readDataB,
    output logic [`REG_ADDR_W-1:0] readAddrA,
    output logic [`REG_ADDR_W-1:0] readAddrB,
    output cpuPkg::opcodeT         dxOp,
    output cpuPkg::aluOpT          dxAluOp,
    output logic                   dxUseImm,
    output logic                   dxMemWrite,
    output logic                   dxMemRead,
    output logic                   dxRegWrite,
    output cpuPkg::wbSelT          dxWbSel,
    output logic [`REG_ADDR_W-1:0] dxDest,
    output logic [`REG_ADDR_W-1:0] dxSrcA,
    output logic [`REG_ADDR_W-1:0] dxSrcB,
    output logic [`XLEN-1:0]       dxValA,
    output logic [`XLEN-1:0]       dxValB,
    output logic [`XLEN-1:0]       dxImm,
    output logic [`XLEN-1:0]       dxTarget,
    output logic [`REG_ADDR_W-1:0] dxShamt,
    output logic [`XLEN-1:0]       dxPc
);
    import cpuPkg::*;

    opcodeT                 op;
    aluOpT                  aluOp;
    wbSelT                  wbSel;
    logic [`REG_ADDR_W-1:0] rd;
    logic [`REG_ADDR_W-1:0] rs;
    logic [`REG_ADDR_W-1:0] rt;
    logic [`REG_ADDR_W-1:0] dest;
    logic                   useImm;
    logic                   memWrite;
    logic                   memRead;
    logic                   regWrite;
    logic                   bubble;

    assign op     = opcodeT'(fdInstr[31:27]);
    assign rd     = fdInstr[26:22];
    assign rs     = fdInstr[21:17];
    assign rt     = fdInstr[16:12];
    assign bubble = stall | flush;

    always_comb begin
        // default is a non-writing add reading rs and rt
        readAddrA = rs;
        readAddrB = rt;
        aluOp     = aluAdd;
        wbSel     = aluResult;
        dest      = rd;
        useImm    = 1'b0;
        memWrite  = 1'b0;
        memRead   = 1'b0;
        regWrite  = 1'b0;
        // unused ports read r0 so they never forward or stall
        case (op)
            opRType: begin
                aluOp    = aluOpT'(fdInstr[6:2]);
                regWrite = 1'b1;
            end
            opAddi: begin
                readAddrB = '0;
                useImm    = 1'b1;
                regWrite  = 1'b1;
            end
            opLw: begin
                readAddrB = '0;
                useImm    = 1'b1;
                memRead   = 1'b1;
                regWrite  = 1'b1;
                wbSel     = memData;
            end
            // address from rs + imm, store data is rd on port B
            opSw: begin
                readAddrB = rd;
                useImm    = 1'b1;
                memWrite  = 1'b1;
            end
            // compare rd against rs
            opBne, opBlt: begin
                readAddrA = rd;
                readAddrB = rs;
            end
            opJal: begin
                readAddrA = '0;
                readAddrB = '0;
                dest      = `REG_ADDR_W'(`LINK_REG);
                regWrite  = 1'b1;
                wbSel     = linkAddr;
            end
            opJr: begin
                readAddrA = '0;
                readAddrB = rd;
            end
            // j and undefined opcodes read and write nothing
            default: begin
                readAddrA = '0;
                readAddrB = '0;
            end
        endcase
        // r0 is never written
        if (dest == '0) begin
            regWrite = 1'b0;
        end
    end

    always_ff @(posedge clock or negedge arstN) begin
        if (!arstN) begin
            dxOp       <= opRType;
            dxAluOp    <= aluAdd;
            dxWbSel    <= aluResult;
            dxUseImm   <= 1'b0;
            dxMemWrite <= 1'b0;
            dxMemRead  <= 1'b0;
            dxRegWrite <= 1'b0;
            dxDest     <= '0;
            dxSrcA     <= '0;
            dxSrcB     <= '0;
            dxValA     <= '0;
            dxValB     <= '0;
            dxImm      <= '0;
            dxTarget   <= '0;
            dxShamt    <= '0;
            dxPc       <= '0;
        end else begin
            // bubble turns the slot into add r0,r0,r0
            dxOp       <= bubble ? opRType : op;
            dxAluOp    <= bubble ? aluAdd : aluOp;
            dxWbSel    <= bubble ? aluResult : wbSel;
            dxUseImm   <= !bubble && useImm;
            dxMemWrite <= !bubble && memWrite;
            dxMemRead  <= !bubble && memRead;
            dxRegWrite <= !bubble && regWrite;
            dxDest     <= bubble ? '0 : dest;
            dxSrcA     <= bubble ? '0 : readAddrA;
            dxSrcB     <= bubble ? '0 : readAddrB;
            // operand payload, only meaningful alongside live control
            dxValA     <= readDataA;
            dxValB     <= readDataB;
            dxImm      <= {{(`XLEN - `IMM_W){fdInstr[`IMM_W-1]}}, fdInstr[`IMM_W-1:0]};
            dxTarget   <= {{(`XLEN - `TARGET_W){1'b0}}, fdInstr[`TARGET_W-1:0]};
            dxShamt    <= fdInstr[11:7];
            dxPc       <= fdPc;
        end
    end

    // only the four writing instructions carry a write enable into execute
    knownWriter: assert property (@(posedge clock) disable iff (!arstN)
        dxRegWrite |-> dxOp inside {opRType, opAddi, opLw, opJal});

endmodule

// File: src/executeStage.sv
/* execute stage: operand bypass, ALU, branch and jump resolution
   and the XM pipeline register */
`include "cpu_defs.svh"

module executeStage (
    input  logic                   clock,
    input  logic                   arstN,
    input  cpuPkg::opcodeT         dxOp,
    input  cpuPkg::aluOpT          dxAluOp,
    input  logic                   dxUseImm,
    input  logic                   dxMemWrite,
    input  logic                   dxMemRead,
    input  logic                   dxRegWrite,
    input  cpuPkg::wbSelT          dxWbSel,
    input  logic [`REG_ADDR_W-1:0] dxDest,
    input  logic [`XLEN-1:0]       dxValA,
    input  logic [`XLEN-1:0]       dxValB,
    input  logic [`XLEN-1:0]       dxImm,
    input  logic [`XLEN-1:0]       dxTarget,
    input  logic [`REG_ADDR_W-1:0] dxShamt,
    input  logic [`XLEN-1:0]       dxPc,
    input  cpuPkg::bypassSelT      bypassA,
    input  cpuPkg::bypassSelT      bypassB,
    input  logic [`XLEN-1:0]       mwWriteData,
    output logic                   redirect,
    output logic [`XLEN-1:0]       redirectPc,
    output logic [`XLEN-1:0]       xmResult,
    output logic [`XLEN-1:0]       xmStoreData,
    output logic                   xmMemWrite,
    output logic                   xmMemRead,
    output logic                   xmRegWrite,
    output logic [`REG_ADDR_W-1:0] xmDest,
    output cpuPkg::wbSelT          xmWbSel,
    output logic [`XLEN-1:0]       xmPc
);
    import cpuPkg::*;

    logic [`XLEN-1:0] opA;
    logic [`XLEN-1:0] opB;
    logic [`XLEN-1:0] aluOut;
    logic             notEqual;
    logic             lessThan;
    pcSelT            pcSel;

    // operand B doubles as store data and the jr target
    assign opA = (bypassA == fromXm) ? xmResult :
                 (bypassA == fromMw) ? mwWriteData : dxValA;
    assign opB = (bypassB == fromXm) ? xmResult :
                 (bypassB == fromMw) ? mwWriteData : dxValB;

    alu uAlu (
        .a       (opA),
        .b       (dxUseImm ? dxImm : opB),
        .shamt   (dxShamt),
        .op      (dxAluOp),
        .result  (aluOut),
        .notEqual(notEqual),
        .lessThan(lessThan)
    );

    always_comb begin
        case (dxOp)
            opBne:      pcSel = notEqual ? branchTarget : sequential;
            opBlt:      pcSel = lessThan ? branchTarget : sequential;
            opJ, opJal: pcSel = jumpTarget;
            opJr:       pcSel = registerTarget;
            default:    pcSel = sequential;
        endcase
    end

    // any non-sequential choice flushes FD and DX
    assign redirect = pcSel != sequential;
    assign redirectPc = (pcSel == branchTarget)   ? dxPc + 1'b1 + dxImm :
                        (pcSel == jumpTarget)     ? dxTarget :
                        (pcSel == registerTarget) ? opB : dxPc + 1'b1;

    always_ff @(posedge clock or negedge arstN) begin
        if (!arstN) begin
            xmMemWrite  <= 1'b0;
            xmMemRead   <= 1'b0;
            xmRegWrite  <= 1'b0;
            xmDest      <= '0;
            xmWbSel     <= aluResult;
            xmResult    <= '0;
            xmStoreData <= '0;
            xmPc        <= '0;
        end else begin
            xmMemWrite  <= dxMemWrite;
            xmMemRead   <= dxMemRead;
            xmRegWrite  <= dxRegWrite;
            xmDest      <= dxDest;
            xmWbSel     <= dxWbSel;
            xmResult    <= aluOut;
            xmStoreData <= opB;
            xmPc        <= dxPc;
        end
    end

endmodule

// File: src/memWriteback.sv
/* memory access from XM, the MW pipeline register and the writeback mux
   drives the data memory port and the register file write port */
`include "cpu_defs.svh"

module memWriteback (
    input  logic                   clock,
    input  logic                   arstN,
    input  logic [`XLEN-1:0]       xmResult,
    input  logic [`XLEN-1:0]       xmStoreData,
    input  logic                   xmMemWrite,
    input  logic                   xmMemRead,
    input  logic                   xmRegWrite,
    input  logic [`REG_ADDR_W-1:0] xmDest,
    input  cpuPkg::wbSelT          xmWbSel,
    input  logic [`XLEN-1:0]       xmPc,
    input  logic [`XLEN-1:0]       dmemReadData,
    output logic [`XLEN-1:0]       dmemAddr,
    output logic [`XLEN-1:0]       dmemWriteData,
    output logic                   dmemWriteEn,
    output logic                   regWriteEn,
    output logic [`REG_ADDR_W-1:0] regWriteAddr,
    output logic [`XLEN-1:0]       regWriteData,
    output logic [`REG_ADDR_W-1:0] mwDest,
    output logic                   mwRegWrite
);
    import cpuPkg::*;

    wbSelT            mwWbSel;
    logic [`XLEN-1:0] mwResult;
    logic [`XLEN-1:0] mwMemData;
    logic [`XLEN-1:0] mwPc;

    // the ALU result is the word address
    assign dmemAddr      = xmResult;
    assign dmemWriteData = xmStoreData;
    assign dmemWriteEn   = xmMemWrite;

    always_ff @(posedge clock or negedge arstN) begin
        if (!arstN) begin
            mwRegWrite <= 1'b0;
            mwDest     <= '0;
            mwWbSel    <= aluResult;
            mwResult   <= '0;
            mwPc       <= '0;
            mwMemData  <= '0;
        end else begin
            mwRegWrite <= xmRegWrite;
            mwDest     <= xmDest;
            mwWbSel    <= xmWbSel;
            mwResult   <= xmResult;
            mwPc       <= xmPc;
            // capture read data for loads only
            if (xmMemRead) begin
                mwMemData <= dmemReadData;
            end
        end
    end

    assign regWriteEn   = mwRegWrite;
    assign regWriteAddr = mwDest;
    // jal links to the instruction after itself
    assign regWriteData = (mwWbSel == memData)  ? mwMemData :
                          (mwWbSel == linkAddr) ? mwPc + 1'b1 : mwResult;

endmodule

// File: src/processor.sv
/* top of the five-stage pipelined CPU, register file included
   instruction and data memories sit outside as combinational-read ports */
`include "cpu_defs.svh"

module processor (
    input  logic              clock,
    input  logic              arstN,
    output logic [`XLEN-1:0]  imemAddr,
    input  logic [`XLEN-1:0]  imemData,
    output logic [`XLEN-1:0]  dmemAddr,
    output logic [`XLEN-1:0]  dmemWriteData,
    output logic              dmemWriteEn,
    input  logic [`XLEN-1:0]  dmemReadData
);
    import cpuPkg::*;

    // fetch to decode
    logic [`XLEN-1:0]       fdInstr;
    logic [`XLEN-1:0]       fdPc;
    // register file read side
    logic [`REG_ADDR_W-1:0] readAddrA;
    logic [`REG_ADDR_W-1:0] readAddrB;
    logic [`XLEN-1:0]       readDataA;
    logic [`XLEN-1:0]       readDataB;
    // DX register
    opcodeT                 dxOp;
    aluOpT                  dxAluOp;
    wbSelT                  dxWbSel;
    logic                   dxUseImm;
    logic                   dxMemWrite;
    logic                   dxMemRead;
    logic                   dxRegWrite;
    logic [`REG_ADDR_W-1:0] dxDest;
    logic [`REG_ADDR_W-1:0] dxSrcA;
    logic [`REG_ADDR_W-1:0] dxSrcB;
    logic [`REG_ADDR_W-1:0] dxShamt;
    logic [`XLEN-1:0]       dxValA;
    logic [`XLEN-1:0]       dxValB;
    logic [`XLEN-1:0]       dxImm;
    logic [`XLEN-1:0]       dxTarget;
    logic [`XLEN-1:0]       dxPc;
    // XM register
    logic [`XLEN-1:0]       xmResult;
    logic [`XLEN-1:0]       xmStoreData;
    logic [`XLEN-1:0]       xmPc;
    logic                   xmMemWrite;
    logic                   xmMemRead;
    logic                   xmRegWrite;
    logic [`REG_ADDR_W-1:0] xmDest;
    wbSelT                  xmWbSel;
    // writeback and feedback
    logic                   regWriteEn;
    logic [`REG_ADDR_W-1:0] regWriteAddr;
    logic [`XLEN-1:0]       regWriteData;
    logic [`REG_ADDR_W-1:0] mwDest;
    logic                   mwRegWrite;
    // hazard and redirect control
    bypassSelT              bypassA;
    bypassSelT              bypassB;
    logic                   stall;
    logic                   redirect;
    logic [`XLEN-1:0]       redirectPc;

    fetchUnit uFetch (.*);

    // a redirect squashes the instruction in decode
    decodeControl uDecode (.flush(redirect), .*);

    hazardUnit uHazard (.*);

    regFile uRegFile (
        .writeEn  (regWriteEn),
        .writeAddr(regWriteAddr),
        .writeData(regWriteData),
        .*
    );

    executeStage uExecute (.mwWriteData(regWriteData), .*);

    memWriteback uMemWb (.*);

endmodule

// File: sim/tbProcessor.sv
/* testbench for the five-stage CPU: models both memories, loads the program
   and the expected store sequence from the test data file, checks each store */
`include "cpu_defs.svh"

module tbProcessor;
    timeunit 1ns;
    timeprecision 100ps;

    // both memories are 256 words deep
    localparam int addrBits     = 8;
    localparam int memWords     = 1 << addrBits;
    localparam int resetCycles  = 4;
    localparam int storeTimeout = 2000;
    localparam int drainCycles  = 40;

    logic             clock;
    logic             arstN;
    logic [`XLEN-1:0] imemAddr;
    logic [`XLEN-1:0] imemData;
    logic [`XLEN-1:0] dmemAddr;
    logic [`XLEN-1:0] dmemWriteData;
    logic             dmemWriteEn;
    logic [`XLEN-1:0] dmemReadData;

    logic [`XLEN-1:0] imem [memWords];
    logic [`XLEN-1:0] dmem [memWords];
    // expected stores in program order
    logic [`XLEN-1:0] expAddr [$];
    logic [`XLEN-1:0] expData [$];
    int               storeCount = 0;
    int               waited;

    processor uut (
        .clock        (clock),
        .arstN        (arstN),
        .imemAddr     (imemAddr),
        .imemData     (imemData),
        .dmemAddr     (dmemAddr),
        .dmemWriteData(dmemWriteData),
        .dmemWriteEn  (dmemWriteEn),
        .dmemReadData (dmemReadData)
    );

    // 20 ns period
    always #10 clock = ~clock;

    // combinational reads, fetches past the ROM see the NOP
    assign imemData     = (imemAddr < memWords) ? imem[imemAddr[addrBits-1:0]] : '0;
    assign dmemReadData = (dmemAddr < memWords) ? dmem[dmemAddr[addrBits-1:0]] : '0;

    // print the reason, then the fail line, then stop
    task automatic abortRun(input string reason);
        $display("%s", reason);
        $display("RESULT: FAIL");
        $fatal(1, "simulation stopped on a failed check");
    endtask

    task automatic checkValue(input string name, input logic [`XLEN-1:0] expected,
                              input logic [`XLEN-1:0] actual);
        assert (actual === expected)
            else abortRun($sformatf("[ERROR] %0d ns: %s expected %h, got %h",
                                    $time, name, expected, actual));
    endtask

    // pipeline must be empty with PC at zero
    task automatic checkIdle();
        checkValue("imemAddr", '0, imemAddr);
        checkValue("dmemWriteEn", '0, {31'b0, dmemWriteEn});
    endtask

    // lines are "I addr word", "D addr word" or "S addr data", hex, '#' starts a comment
    task automatic loadTestData();
        int               fd;
        int               c;
        int               n;
        logic [`XLEN-1:0] addr;
        logic [`XLEN-1:0] word;
        // unlisted ROM words are NOPs, RAM fill follows the address
        for (int i = 0; i < memWords; i++) begin
            imem[i] = '0;
            dmem[i] <= 32'hd000_0000 | 32'(i);
        end
        fd = $fopen("sim/processor_testdata.txt", "r");
        assert (fd != 0)
            else abortRun("could not open sim/processor_testdata.txt");
        c = $fgetc(fd);
        while (c != -1) begin
            if (c == "#") begin
                // skip the rest of the line
                while (c != -1 && c != 10) begin
                    c = $fgetc(fd);
                end
            end else if (c == "I" || c == "D" || c == "S") begin
                n = $fscanf(fd, "%h %h", addr, word);
                assert (n == 2)
                    else abortRun("test data line has no address and word after its kind");
                if (c == "S") begin
                    expAddr.push_back(addr);
                    expData.push_back(word);
                end else begin
                    assert (addr < memWords)
                        else abortRun($sformatf("test data address %h is outside memory", addr));
                    if (c == "I") begin
                        imem[addr[addrBits-1:0]] = word;
                    end else begin
                        dmem[addr[addrBits-1:0]] <= word;
                    end
                end
            end else begin
                assert (c inside {9, 10, 13, 32})
                    else abortRun($sformatf("test data holds an unknown line kind '%c'", c));
            end
            if (c != -1) begin
                c = $fgetc(fd);
            end
        end
        $fclose(fd);
        assert (expAddr.size() > 0)
            else abortRun("test data lists no expected stores");
    endtask

    // store monitor, DUT outputs still hold the pre-edge values here
    always @(posedge clock) begin
        if (dmemWriteEn) begin
            assert (storeCount < expAddr.size())
                else abortRun($sformatf("unexpected extra store of %h to address %h",
                                        dmemWriteData, dmemAddr));
            checkValue("dmemAddr", expAddr[storeCount], dmemAddr);
            checkValue("dmemWriteData", expData[storeCount], dmemWriteData);
            if (dmemAddr < memWords) begin
                dmem[dmemAddr[addrBits-1:0]] <= dmemWriteData;
            end
            storeCount <= storeCount + 1;
        end
    end

    initial begin
        clock = 1'b0;
        arstN = 1'b0;
        loadTestData();
        // reset spans four rising edges
        for (int i = 1; i < resetCycles; i++) begin
            @(negedge clock);
            checkIdle();
        end
        @(posedge clock);
        arstN <= 1'b1;
        // first cycle out of reset still fetches address zero
        @(negedge clock);
        checkIdle();
        waited = 0;
        while (storeCount < expAddr.size() && waited < storeTimeout) begin
            @(negedge clock);
            waited++;
        end
        assert (storeCount == expAddr.size())
            else abortRun($sformatf("timeout: store %0d of %0d never came within %0d cycles",
                                    storeCount + 1, expAddr.size(), storeTimeout));
        // the program now spins on its last jump, any store here is wrong
        for (int i = 0; i < drainCycles; i++) begin
            @(negedge clock);
        end
        if (storeCount == expAddr.size()) begin
            $display("RESULT: PASS");
            $finish;
        end else begin
            abortRun($sformatf("saw %0d stores, expected %0d", storeCount, expAddr.size()));
        end
    end

endmodule

// File: sim/processor_testdata.txt
# kind addr word, all hex: I = instruction ROM, D = initial data RAM,
# S = expected store address and data in program order; poison stores hit C8
I 00 2D000BAD  # addi r20, r0, 0xbad   poison value
I 01 28400005  # addi r1, r0, 5
I 02 2881FFFD  # addi r2, r0, -3
I 03 00C22000  # add  r3, r1, r2       = 2
I 04 01061004  # sub  r4, r3, r1       = -3
I 05 01481008  # and  r5, r4, r1       = 5
I 06 018A200C  # or   r6, r5, r2       = -3
I 07 01CC0210  # sll  r7, r6, 4        = ffffffd0
I 08 020E0114  # sra  r8, r7, 2        = fffffff4
I 09 2A500064  # addi r9, r8, 100      = 58
I 0A 3A400010  # sw   r9, 0x10(r0)
I 0B 3A000011  # sw   r8, 0x11(r0)
I 0C 39800012  # sw   r6, 0x12(r0)
I 0D 39400013  # sw   r5, 0x13(r0)
I 0E 38C00014  # sw   r3, 0x14(r0)
I 0F 39C00015  # sw   r7, 0x15(r0)
I 10 2A800028  # addi r10, r0, 0x28
I 11 42D40000  # lw   r11, 0(r10)
I 12 03161000  # add  r12, r11, r1     load-use stall
I 13 3B140001  # sw   r12, 1(r10)
I 14 10440003  # bne  r1, r2, +3       taken to 18
I 15 3D0000C8  # poison
I 16 3D0000C8  # poison
I 17 3D0000C8  # poison
I 18 30820002  # blt  r2, r1, +2       taken to 1b
I 19 3D0000C8  # poison
I 1A 3D0000C8  # poison
I 1B 30440002  # blt  r1, r2, +2       not taken
I 1C 2B40004D  # addi r13, r0, 77
I 1D 3B400032  # sw   r13, 0x32(r0)
I 1E 18000028  # jal  0x28
I 1F 38400033  # sw   r1, 0x33(r0)     after the return
I 20 08000024  # j    0x24
I 21 3D0000C8  # poison
I 22 3D0000C8  # poison
I 23 3D0000C8  # poison, skipped by the jump
I 24 08000024  # j    0x24             end of program
I 28 3FC00034  # sw   r31, 0x34(r0)    subroutine
I 29 27C00000  # jr   r31
I 2A 3D0000C8  # poison
I 2B 3D0000C8  # poison
D 28 00001234
S 10 00000058
S 11 FFFFFFF4
S 12 FFFFFFFD
S 13 00000005
S 14 00000002
S 15 FFFFFFD0
S 29 00001239
S 32 0000004D
S 34 0000001F
S 33 00000005

// File: tb.f
+incdir+include
src/cpuPkg.sv
src/alu.sv
src/regFile.sv
src/hazardUnit.sv
src/fetchUnit.sv
src/decodeControl.sv
src/executeStage.sv
src/memWriteback.sv
src/processor.sv
sim/tbProcessor.sv

// File: run.sh
#!/bin/sh
# build and run the CPU testbench with Verilator from the project root
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --timescale 1ns/100ps -Wno-fatal \
    --top-module tbProcessor -f tb.f
simOutput=$(./obj_dir/VtbProcessor 2>&1) || true
echo "$simOutput"
if echo "$simOutput" | grep -qx "RESULT: PASS"; then
    exit 0
fi
exit 1
